// File: verilog/resp_pkg.sv
`default_nettype none

package resp_pkg;

  // width of one full response word as delivered by a response source
  localparam int default_resp_nbits = 32;

  // width of one chunk on the narrow link
  // the response width has to be a whole multiple of it
  localparam int default_chunk_nbits = 8;

  // number of response sources sharing the link, at least 2
  localparam int default_ninputs = 3;

  // states of one packet disassembler
  // in idle it waits for a response word
  // in send it offers the held word chunk by chunk
  typedef enum logic {
    idle = 1'b0,
    send = 1'b1
  } disasm_state_e;

endpackage

`default_nettype wire

// File: verilog/chunk_counter.sv
`timescale 1ns/1ps
`default_nettype none

module chunk_counter
  import resp_pkg::*;
#(
  parameter int chunk_nbits = default_chunk_nbits,
  parameter int resp_nbits  = default_resp_nbits
) (
  input  logic clk,
  input  logic reset,
  input  logic clear,
  input  logic step,
  output logic last
);

  // number of chunks in one message and the width needed to count them
  localparam int nchunks   = resp_nbits / chunk_nbits;
  localparam int cnt_nbits = (nchunks > 1) ? $clog2(nchunks) : 1;
  localparam logic [cnt_nbits-1:0] last_idx = cnt_nbits'(nchunks - 1);

  // index of the chunk that the disassembler is offering right now
  logic [cnt_nbits-1:0] idx;

  // a response that does not split evenly would lose its low bits
  if (resp_nbits % chunk_nbits != 0) begin : g_width_check
    $error("response width must be a multiple of the chunk width");
  end

  // clear wins over step since a new message always starts at chunk 0
  always_ff @(posedge clk) begin
    if (reset) begin
      idx <= '0;
    end else if (clear) begin
      idx <= '0;
    end else if (step) begin
      idx <= idx + 1'b1;
    end
  end

  assign last = (idx == last_idx);

  // the controller leaves the final chunk to the state change, so the
  // counter is never asked to move past the end of a message
  step_not_past_last: assert property (@(posedge clk) disable iff (reset) step |-> !last);

endmodule

`default_nettype wire

// File: verilog/disasm_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module disasm_ctrl
  import resp_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic resp_val,
  input  logic chunk_rdy,
  input  logic last,
  output logic resp_rdy,
  output logic load,
  output logic shift,
  output logic chunk_val
);

  disasm_state_e state;
  disasm_state_e state_next;

  // a chunk leaves on this edge
  logic chunk_xfer;

  // the handshakes come straight from the state so neither side waits
  // on the other before raising its val or rdy
  assign resp_rdy  = (state == idle);
  assign chunk_val = (state == send);

  // load the holding register and restart the counter on an accepted response
  assign load = resp_val & resp_rdy;

  assign chunk_xfer = chunk_val & chunk_rdy;

  // move on to the next chunk after every transfer except the final one,
  // the final transfer ends the message instead
  assign shift = chunk_xfer & ~last;

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (load) begin
          state_next = send;
        end
      end
      send: begin
        // resp_rdy rises in the cycle right after the last chunk leaves
        if (chunk_xfer && last) begin
          state_next = idle;
        end
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/packet_disassembler.sv
`timescale 1ns/1ps
`default_nettype none

module packet_disassembler
  import resp_pkg::*;
#(
  parameter int resp_nbits  = default_resp_nbits,
  parameter int chunk_nbits = default_chunk_nbits
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   resp_val,
  output logic                   resp_rdy,
  input  logic [resp_nbits-1:0]  resp_msg,
  output logic                   chunk_val,
  input  logic                   chunk_rdy,
  output logic [chunk_nbits-1:0] chunk_msg
);

  // control strobes between the state machine, the counter and the register
  logic load;
  logic shift;
  logic last;

  // response held here while its chunks go out
  // the chunk on offer always sits in the top bits
  logic [resp_nbits-1:0] hold_q;

  disasm_ctrl disasm_ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .resp_val  (resp_val),
    .chunk_rdy (chunk_rdy),
    .last      (last),
    .resp_rdy  (resp_rdy),
    .load      (load),
    .shift     (shift),
    .chunk_val (chunk_val)
  );

  // the counter restarts whenever a new response is loaded
  chunk_counter #(
    .chunk_nbits (chunk_nbits),
    .resp_nbits  (resp_nbits)
  ) chunk_counter_i (
    .clk   (clk),
    .reset (reset),
    .clear (load),
    .step  (shift),
    .last  (last)
  );

  // shifting left brings the next lower chunk up, so the most
  // significant chunk goes first
  always_ff @(posedge clk) begin
    if (load) begin
      hold_q <= resp_msg;
    end else if (shift) begin
      hold_q <= hold_q << chunk_nbits;
    end
  end

  assign chunk_msg = hold_q[resp_nbits-1 -: chunk_nbits];

  // a stalled chunk must not change under the arbiter
  chunk_stable: assert property (@(posedge clk) disable iff (reset)
    chunk_val && !chunk_rdy |=> chunk_val && $stable(chunk_msg));

  // the disassembler either takes a response or sends one, never both
  rdy_val_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(resp_rdy && chunk_val));

endmodule

`default_nettype wire

// File: verilog/response_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module response_arbiter
  import resp_pkg::*;
#(
  parameter int chunk_nbits = default_chunk_nbits,
  parameter int ninputs     = default_ninputs
) (
  input  logic clk,
  input  logic reset,
  input  logic chunk_val [ninputs],
  output logic chunk_rdy [ninputs],
  input  logic [chunk_nbits-1:0] chunk_msg [ninputs],
  output logic out_val,
  input  logic out_rdy,
  output logic [$clog2(ninputs)+chunk_nbits-1:0] out_msg
);

  // width of the source index put in front of every chunk
  localparam int idx_nbits = $clog2(ninputs);

  // input that owns the link in this cycle
  logic [idx_nbits-1:0] grant;

  // owner in the cycle before, kept until its message is done
  logic [idx_nbits-1:0] prev_grant;

  // lowest index with a chunk waiting
  logic [idx_nbits-1:0] enc;

  // rdy lines gathered in one vector for the one-hot check
  logic [ninputs-1:0] rdy_vec;

  // scanning from the top down lets the lowest waiting index win
  // an idle link falls back to input 0
  always_comb begin
    enc = '0;
    for (int i = ninputs - 1; i >= 0; i--) begin
      if (chunk_val[i]) begin
        enc = idx_nbits'(i);
      end
    end
  end

  // a disassembler holds val high from its first chunk to its last, so
  // the grant only moves once the previous owner's val has dropped
  always_comb begin
    if (!chunk_val[prev_grant]) begin
      grant = enc;
    end else begin
      grant = prev_grant;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prev_grant <= '0;
    end else begin
      prev_grant <= grant;
    end
  end

  // only the granted input sees the link's back-pressure
  for (genvar i = 0; i < ninputs; i++) begin : g_rdy
    assign chunk_rdy[i] = (grant == idx_nbits'(i)) ? out_rdy : 1'b0;
    assign rdy_vec[i]   = chunk_rdy[i];
  end

  // no pipeline here, the granted chunk goes straight through
  // out_val already includes out_rdy, so it marks a transfer by itself
  assign out_val = chunk_val[grant] & chunk_rdy[grant];

  // the source index goes in front so the far side can sort the chunks
  assign out_msg = {grant, chunk_msg[grant]};

  // two disassemblers must never see the same chunk leave
  single_rdy: assert property (@(posedge clk) disable iff (reset) $onehot0(rdy_vec));

endmodule

`default_nettype wire

// File: verilog/response_path.sv
`timescale 1ns/1ps
`default_nettype none

module response_path
  import resp_pkg::*;
#(
  parameter int resp_nbits  = default_resp_nbits,
  parameter int chunk_nbits = default_chunk_nbits,
  parameter int ninputs     = default_ninputs
) (
  input  logic clk,
  input  logic reset,
  // one response port per source
  input  logic resp_val [ninputs],
  output logic resp_rdy [ninputs],
  input  logic [resp_nbits-1:0] resp_msg [ninputs],
  // shared chunk stream towards the serial link
  output logic out_val,
  input  logic out_rdy,
  output logic [$clog2(ninputs)+chunk_nbits-1:0] out_msg
);

  // chunk streams from the disassemblers into the arbiter
  logic                   chunk_val [ninputs];
  logic                   chunk_rdy [ninputs];
  logic [chunk_nbits-1:0] chunk_msg [ninputs];

  // each source gets its own disassembler, so up to ninputs
  // messages can be in flight at once
  for (genvar i = 0; i < ninputs; i++) begin : g_disasm
    packet_disassembler #(
      .resp_nbits  (resp_nbits),
      .chunk_nbits (chunk_nbits)
    ) packet_disassembler_i (
      .clk       (clk),
      .reset     (reset),
      .resp_val  (resp_val[i]),
      .resp_rdy  (resp_rdy[i]),
      .resp_msg  (resp_msg[i]),
      .chunk_val (chunk_val[i]),
      .chunk_rdy (chunk_rdy[i]),
      .chunk_msg (chunk_msg[i])
    );
  end

  // the arbiter keeps whole messages together on the link
  response_arbiter #(
    .chunk_nbits (chunk_nbits),
    .ninputs     (ninputs)
  ) response_arbiter_i (
    .clk       (clk),
    .reset     (reset),
    .chunk_val (chunk_val),
    .chunk_rdy (chunk_rdy),
    .chunk_msg (chunk_msg),
    .out_val   (out_val),
    .out_rdy   (out_rdy),
    .out_msg   (out_msg)
  );

endmodule

`default_nettype wire

// File: tb/response_path_tb.sv
`timescale 1ns/1ps
`default_nettype none

module response_path_tb
  import resp_pkg::*;
();

  localparam int resp_nbits  = default_resp_nbits;
  localparam int chunk_nbits = default_chunk_nbits;
  localparam int ninputs     = default_ninputs;
  localparam int idx_nbits   = $clog2(ninputs);
  localparam int msg_nbits   = idx_nbits + chunk_nbits;
  localparam int nchunks     = resp_nbits / chunk_nbits;
  // cycle limits for the two kinds of wait loop
  localparam int offer_limit = 200;
  localparam int drain_limit = 1000;

  logic clk;
  logic reset;
  logic resp_val [ninputs];
  logic resp_rdy [ninputs];
  logic [resp_nbits-1:0] resp_msg [ninputs];
  logic out_val;
  logic out_rdy;
  logic [msg_nbits-1:0] out_msg;

  // responses accepted by each source and not yet fully sent
  logic [resp_nbits-1:0] sent_q [ninputs][$];
  // source of every message in the order it finished on the link
  int finished_q [$];
  // chunk position expected next for each source
  int chunk_pos [ninputs];
  int xfer_count;
  int value_errors;
  int other_errors;
  // a message is on the link and owner is its source
  logic in_msg;
  int owner;
  logic [31:0] lfsr;
  logic rdy_random;

  response_path #(
    .resp_nbits  (resp_nbits),
    .chunk_nbits (chunk_nbits),
    .ninputs     (ninputs)
  ) response_path_i (
    .clk      (clk),
    .reset    (reset),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .out_msg  (out_msg)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // right shifting Galois LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // one LFSR step per bit, the lowest state bit is the bit taken
  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // chunk 0 is the most significant slice of the response word
  function automatic logic [chunk_nbits-1:0] expected_chunk(
    input logic [resp_nbits-1:0] word,
    input int pos
  );
    int sh;
    sh = (nchunks - 1 - pos) * chunk_nbits;
    return chunk_nbits'(word >> sh);
  endfunction

  function automatic int pending_total();
    int n;
    n = 0;
    for (int i = 0; i < ninputs; i++) begin
      n += sent_q[i].size();
    end
    return n;
  endfunction

  // waits for the next edge, reports which responses were taken there,
  // then drives out_rdy 1 ns later
  task automatic next_cycle(output logic [ninputs-1:0] took);
    logic [31:0] bits;
    @(posedge clk);
    for (int i = 0; i < ninputs; i++) begin
      took[i] = resp_val[i] & resp_rdy[i];
    end
    #1;
    if (rdy_random) begin
      take_bits(1, bits);
      out_rdy = bits[0];
    end else begin
      out_rdy = 1'b1;
    end
  endtask

  // presents a random word on every source in mask and holds each one
  // until its disassembler takes it
  task automatic offer_responses(input logic [ninputs-1:0] mask);
    logic [ninputs-1:0] pending;
    logic [ninputs-1:0] took;
    logic [31:0] word;
    int waited;
    pending = mask;
    for (int i = 0; i < ninputs; i++) begin
      if (mask[i]) begin
        take_bits(resp_nbits, word);
        resp_val[i] = 1'b1;
        resp_msg[i] = word[resp_nbits-1:0];
      end
    end
    waited = 0;
    while (pending != '0 && waited < offer_limit) begin
      next_cycle(took);
      for (int i = 0; i < ninputs; i++) begin
        if (took[i] && pending[i]) begin
          pending[i]  = 1'b0;
          resp_val[i] = 1'b0;
        end
      end
      waited++;
    end
    if (pending != '0) begin
      other_errors++;
      $display("timeout at %0t: sources %b never accepted their response", $time, pending);
    end
  endtask

  task automatic wait_drain();
    logic [ninputs-1:0] took;
    int waited;
    waited = 0;
    while (pending_total() != 0 && waited < drain_limit) begin
      next_cycle(took);
      waited++;
    end
    if (pending_total() != 0) begin
      other_errors++;
      $display("timeout at %0t: %0d responses still not sent", $time, pending_total());
    end
  endtask

  // the monitor samples at the rising edge, where every input has been
  // stable since 1 ns after the edge before
  always @(posedge clk) begin : monitor
    int src;
    logic [chunk_nbits-1:0] exp_chunk;
    if (!reset) begin
      // a source is busy from acceptance until its last chunk has left
      for (int i = 0; i < ninputs; i++) begin
        assert (resp_rdy[i] == (sent_q[i].size() == 0)) else begin
          value_errors++;
          $display("Fail at %0t: resp_rdy[%0d] is %b, expected %b", $time, i,
                   resp_rdy[i], sent_q[i].size() == 0);
        end
      end
      assert (!(out_val && !out_rdy)) else begin
        other_errors++;
        $display("out_val was high while out_rdy was low at %0t", $time);
      end
      if (out_val) begin
        xfer_count++;
        src = int'(out_msg[msg_nbits-1 -: idx_nbits]);
        if (in_msg) begin
          assert (src == owner) else begin
            value_errors++;
            $display("Fail at %0t: out_msg source is %0d, expected %0d", $time, src, owner);
          end
        end
        if (src >= ninputs || sent_q[src].size() == 0) begin
          other_errors++;
          $display("a chunk from source %0d arrived with no response pending at %0t",
                   src, $time);
        end else begin
          exp_chunk = expected_chunk(sent_q[src][0], chunk_pos[src]);
          assert (out_msg[chunk_nbits-1:0] == exp_chunk) else begin
            value_errors++;
            $display("Fail at %0t: out_msg chunk is %h, expected %h", $time,
                     out_msg[chunk_nbits-1:0], exp_chunk);
          end
          if (chunk_pos[src] == nchunks - 1) begin
            chunk_pos[src] = 0;
            void'(sent_q[src].pop_front());
            finished_q.push_back(src);
            in_msg = 1'b0;
          end else begin
            chunk_pos[src]++;
            in_msg = 1'b1;
            owner  = src;
          end
        end
      end
      // responses taken at this edge only show up on the link later
      for (int i = 0; i < ninputs; i++) begin
        if (resp_val[i] && resp_rdy[i]) begin
          sent_q[i].push_back(resp_msg[i]);
        end
      end
    end
  end

  initial begin : stimulus
    logic [ninputs-1:0] took;
    logic [31:0] bits;
    int start;
    reset        = 1'b1;
    out_rdy      = 1'b0;
    rdy_random   = 1'b0;
    lfsr         = 32'h41d82a46;
    xfer_count   = 0;
    value_errors = 0;
    other_errors = 0;
    in_msg       = 1'b0;
    owner        = 0;
    for (int i = 0; i < ninputs; i++) begin
      resp_val[i]  = 1'b0;
      resp_msg[i]  = '0;
      chunk_pos[i] = 0;
    end
    repeat (4) @(posedge clk);
    #1;
    reset   = 1'b0;
    out_rdy = 1'b1;

    // one message per source with the link always ready
    for (int i = 0; i < ninputs; i++) begin
      offer_responses(ninputs'(1) << i);
      wait_drain();
    end

    // all sources loaded at one edge leave back to back by index
    next_cycle(took);
    finished_q.delete();
    offer_responses('1);
    start = xfer_count;
    repeat (ninputs * nchunks) next_cycle(took);
    assert (xfer_count - start == ninputs * nchunks) else begin
      other_errors++;
      $display("the link had gaps while all sources were loaded and out_rdy was high");
    end
    assert (finished_q.size() == ninputs) else begin
      other_errors++;
      $display("only %0d of %0d messages finished in the burst", finished_q.size(), ninputs);
    end
    for (int i = 0; i < finished_q.size(); i++) begin
      assert (finished_q[i] == i) else begin
        value_errors++;
        $display("Fail at %0t: message order source is %0d, expected %0d", $time,
                 finished_q[i], i);
      end
    end

    // random loads on all sources against a random out_rdy
    rdy_random = 1'b1;
    repeat (80) begin
      take_bits(ninputs, bits);
      offer_responses(bits[ninputs-1:0]);
      take_bits(2, bits);
      repeat (bits[1:0]) next_cycle(took);
    end
    wait_drain();
    rdy_random = 1'b0;
    next_cycle(took);

    $display("chunks %0d, value errors %0d, other errors %0d", xfer_count, value_errors,
             other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
verilog/resp_pkg.sv
verilog/chunk_counter.sv
verilog/disasm_ctrl.sv
verilog/packet_disassembler.sv
verilog/response_arbiter.sv
verilog/response_path.sv
tb/response_path_tb.sv

// File: Bender.yml
package:
  name: response_path

sources:
  - files:
      - verilog/resp_pkg.sv
      - verilog/chunk_counter.sv
      - verilog/disasm_ctrl.sv
      - verilog/packet_disassembler.sv
      - verilog/response_arbiter.sv
      - verilog/response_path.sv
  - target: test
    files:
      - tb/response_path_tb.sv
